// File: eth_mac_gmii.f
+incdir+rtl
rtl/eth_mac_pkg.sv
rtl/eth_crc32.sv
rtl/tx_credit_fifo.sv
rtl/gmii_tx_engine.sv
rtl/gmii_rx_decode.sv
rtl/mac_stats.sv
rtl/eth_mac_gmii.sv
bench/eth_mac_gmii_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MAC testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module eth_mac_gmii_tb \
    -f eth_mac_gmii.f -Mdir obj_dir -o sim_eth_mac_gmii

./obj_dir/sim_eth_mac_gmii > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1

// File: bench/eth_mac_gmii_tb.sv
// Ethernet MAC loopback testbench
`timescale 1ns/1ps
`default_nettype none
`include "eth_mac_consts.svh"

module eth_mac_gmii_tb;

    import eth_mac_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DEPTH           = `ETH_TX_FIFO_DEPTH;
    localparam int MIN_DATA        = `ETH_MIN_FRAME_LEN - 4; // Padded length without the FCS.
    localparam int IFG             = `ETH_IFG_BYTES;
    localparam int QUANTUM         = `ETH_PAUSE_QUANTUM_CYCLES;
    localparam int NUM_LOOP        = 20;
    localparam int NUM_FRAMES      = NUM_LOOP + 4;
    localparam int MAX_QUANTA      = 8;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 200 + MAX_QUANTA * QUANTUM + 16;
    localparam int CORRUPT_IDX     = 12;              // Data byte hit by an injected error.
    localparam int CORRUPT_POS     = 8 + CORRUPT_IDX; // Same byte counted from the preamble.
    localparam int K_NORMAL        = 0;
    localparam int K_FLIP          = 1;
    localparam int K_ERR           = 2;

    logic        gtx_clk;
    logic        gtx_rst;
    tx_beat_t    tx_in;
    logic        tx_valid;
    logic        tx_credit;
    rx_beat_t    rx_out;
    rx_status_t  rx_status;
    mac_counts_t counts;
    logic [7:0]  gmii_rxd;
    logic        gmii_rx_dv;
    logic        gmii_rx_er;
    logic [7:0]  gmii_txd;
    logic        gmii_tx_en;
    logic        gmii_tx_er;

    // Host and reference model state.
    integer      seed;
    int          credits;
    int          credits_back;
    int          bytes_sent;
    tx_beat_t    host_q [$];
    logic [7:0]  frame_buf [$];
    logic [7:0]  exp_bytes [$];
    int          exp_len [$];
    int          exp_test [$];
    int          exp_kind [$];
    logic        exp_pause [$];
    logic [15:0] exp_quanta [$];
    int          kind_of [NUM_FRAMES];
    int          gen_idx = 0;
    int          tally_tx = 0;
    int          tally_good = 0;
    int          tally_fcs = 0;
    int          tally_pause = 0;
    int          test_err [1:6] = '{0, 0, 0, 0, 0, 0};
    int          num_checks = 0;
    int          total_err;
    int          failed_tests;

    // Monitor state.
    int          cyc;
    int          low_run;
    int          rises;
    int          gap_checks;
    int          pause_checks;
    int          pause_cycle;
    int          pause_wait;
    logic        en_prev;
    logic        pause_armed;
    logic [7:0]  rx_buf [$];
    int          last_cnt;
    int          last_pos;
    int          rx_count;

    // Loopback state.
    logic        lb_prev;
    int          lb_count;
    int          lb_frame;
    int          lb_pos;

    eth_mac_gmii i_dut (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .tx_in      (tx_in),
        .tx_valid   (tx_valid),
        .tx_credit  (tx_credit),
        .rx_out     (rx_out),
        .rx_status  (rx_status),
        .counts     (counts),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    initial begin
        gtx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gtx_clk = ~gtx_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with frames still outstanding",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_value(input int test_id, input string what,
                               input logic [63:0] got, input logic [63:0] exp);
        num_checks++;
        assert (got == exp) else begin
            $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
            test_err[test_id]++;
        end
    endtask

    task automatic random_frame(input int len);
        frame_buf.delete();
        for (int i = 0; i < len; i++) begin
            frame_buf.push_back(8'($random(seed)));
        end
    endtask

    task automatic pause_frame(input logic [15:0] quanta);
        logic [47:0] dst;
        logic [15:0] etype;
        logic [15:0] opcode;
        dst    = `ETH_PAUSE_DST;
        etype  = `ETH_CTRL_TYPE;
        opcode = `ETH_PAUSE_OPCODE;
        frame_buf.delete();
        for (int i = 0; i < 6; i++) begin
            frame_buf.push_back(dst[47 - 8 * i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            frame_buf.push_back(8'($random(seed))); // Source address.
        end
        frame_buf.push_back(etype[15:8]);
        frame_buf.push_back(etype[7:0]);
        frame_buf.push_back(opcode[15:8]);
        frame_buf.push_back(opcode[7:0]);
        frame_buf.push_back(quanta[15:8]);
        frame_buf.push_back(quanta[7:0]);
    endtask

    // Hands frame_buf to the host and records what the receiver should report.
    task automatic queue_frame(input int test_id, input int kind);
        int          n;
        tx_beat_t    beat;
        logic [7:0]  padded [$];
        logic [47:0] dst;
        logic        pz;
        n   = frame_buf.size();
        dst = `ETH_PAUSE_DST;
        for (int i = 0; i < n; i++) begin
            beat.data = frame_buf[i];
            beat.last = (i == n - 1);
            host_q.push_back(beat);
        end
        padded = frame_buf;
        while (padded.size() < MIN_DATA) begin
            padded.push_back(8'h00);
        end
        pz = (kind == K_NORMAL);
        for (int i = 0; i < 6; i++) begin
            pz = pz && (padded[i] == dst[47 - 8 * i -: 8]);
        end
        pz = pz && ({padded[12], padded[13]} == `ETH_CTRL_TYPE);
        pz = pz && ({padded[14], padded[15]} == `ETH_PAUSE_OPCODE);
        if (kind == K_FLIP) begin
            padded[CORRUPT_IDX] = padded[CORRUPT_IDX] ^ 8'h01;
        end
        foreach (padded[i]) begin
            exp_bytes.push_back(padded[i]);
        end
        exp_len.push_back(padded.size());
        exp_test.push_back(test_id);
        exp_kind.push_back(kind);
        exp_pause.push_back(pz);
        exp_quanta.push_back({padded[16], padded[17]});
        kind_of[gen_idx] = kind;
        gen_idx++;
        tally_tx++;
        if (kind == K_NORMAL) begin
            tally_good++;
        end
        if (kind == K_FLIP) begin
            tally_fcs++;
        end
        if (pz) begin
            tally_pause++;
        end
    endtask

    // Compares one finished receive frame with the model.
    task automatic frame_done();
        int          n;
        int          tid;
        int          kind;
        logic        pz;
        logic [15:0] q;
        logic [7:0]  b;
        num_checks++;
        assert (exp_len.size() != 0) else begin
            $display("Unexpected receive frame at %0d ns", $time);
            test_err[1]++;
        end
        if (exp_len.size() != 0) begin
            n    = exp_len.pop_front();
            tid  = exp_test.pop_front();
            kind = exp_kind.pop_front();
            pz   = exp_pause.pop_front();
            q    = exp_quanta.pop_front();
            check_value(tid, "frame length", rx_buf.size(), n);
            for (int i = 0; i < n; i++) begin
                b = exp_bytes.pop_front();
                if (i < rx_buf.size()) begin
                    check_value(tid, "data byte", rx_buf[i], b);
                end
            end
            check_value(tid, "last count", last_cnt, 1);
            check_value(tid, "last position", last_pos, n - 1);
            check_value(tid, "good", rx_status.good, kind == K_NORMAL);
            check_value(tid, "bad_fcs", rx_status.bad_fcs, kind == K_FLIP);
            check_value(tid, "bad_frame", rx_status.bad_frame, kind == K_ERR);
            check_value(tid, "pause_valid", rx_status.pause_valid, pz);
            if (pz) begin
                check_value(tid, "pause_quanta", rx_status.pause_quanta, q);
                pause_armed = 1'b1; // Next transmit must wait out the timer.
                pause_cycle = cyc;
                pause_wait  = q * QUANTUM;
            end
        end
        rx_buf.delete();
        last_cnt = 0;
        rx_count++;
    endtask

    task automatic wait_frames(input int target, input int test_id);
        int waited;
        int limit;
        waited = 0;
        limit  = (target - rx_count) * 200 + MAX_QUANTA * QUANTUM;
        while (rx_count < target && waited < limit) begin
            @(posedge gtx_clk);
            waited++;
        end
        num_checks++;
        assert (rx_count >= target) else begin
            $display("Receive timed out, %0d of %0d frames arrived", rx_count, target);
            test_err[test_id]++;
        end
    endtask

    task automatic report_test(input int id, input string name);
        $display("[%0d] %s: %s, %0d errors", id, name,
                 (test_err[id] == 0) ? "pass" : "fail", test_err[id]);
    endtask

    // Credit-limited host.
    always @(negedge gtx_clk) begin
        if (gtx_rst) begin
            credits      = DEPTH;
            credits_back = 0;
            bytes_sent   = 0;
            tx_valid     = 1'b0;
            tx_in        = '0;
        end else begin
            if (tx_credit) begin
                credits++;
                credits_back++;
            end
            if (host_q.size() > 0 && credits > 0) begin
                tx_in    = host_q.pop_front();
                tx_valid = 1'b1;
                credits--;
                bytes_sent++;
            end else begin
                tx_valid = 1'b0;
            end
            num_checks++;
            assert (credits >= 0 && credits <= DEPTH) else begin
                $display("Host credit count left 0..%0d at %0d ns, now %0d",
                         DEPTH, $time, credits);
                test_err[2]++;
            end
        end
    end

    // GMII loopback with error injection.
    always @(negedge gtx_clk) begin
        if (gtx_rst) begin
            lb_prev    = 1'b0;
            lb_count   = 0;
            lb_frame   = 0;
            lb_pos     = 0;
            gmii_rxd   = '0;
            gmii_rx_dv = 1'b0;
            gmii_rx_er = 1'b0;
        end else begin
            if (gmii_tx_en && !lb_prev) begin
                lb_frame = lb_count;
                lb_count++;
                lb_pos   = 0;
            end else if (gmii_tx_en) begin
                lb_pos++;
            end
            lb_prev    = gmii_tx_en;
            gmii_rxd   = gmii_txd;
            gmii_rx_dv = gmii_tx_en;
            gmii_rx_er = 1'b0;
            if (gmii_tx_en && lb_pos == CORRUPT_POS && lb_frame < NUM_FRAMES) begin
                if (kind_of[lb_frame] == K_FLIP) begin
                    gmii_rxd = gmii_txd ^ 8'h01;
                end else if (kind_of[lb_frame] == K_ERR) begin
                    gmii_rx_er = 1'b1;
                end
            end
        end
    end

    // Transmit timing and receive frames.
    always @(negedge gtx_clk) begin
        if (gtx_rst) begin
            cyc          = 0;
            low_run      = 0;
            rises        = 0;
            gap_checks   = 0;
            pause_checks = 0;
            en_prev      = 1'b0;
            pause_armed  = 1'b0;
            last_cnt     = 0;
            last_pos     = -1;
            rx_count     = 0;
        end else begin
            cyc++;
            if (gmii_tx_en && !en_prev) begin
                if (rises > 0) begin
                    gap_checks++;
                    num_checks++;
                    assert (low_run >= IFG) else begin
                        $display("Inter-frame gap of %0d cycles too short at %0d ns",
                                 low_run, $time);
                        test_err[5]++;
                    end
                end
                if (pause_armed) begin
                    pause_checks++;
                    num_checks++;
                    assert (cyc - pause_cycle >= pause_wait) else begin
                        $display("Frame started %0d cycles into a %0d cycle pause at %0d ns",
                                 cyc - pause_cycle, pause_wait, $time);
                        test_err[4]++;
                    end
                    pause_armed = 1'b0;
                end
                rises++;
            end
            low_run = gmii_tx_en ? 0 : low_run + 1;
            en_prev = gmii_tx_en;
            num_checks++;
            assert (!gmii_tx_er) else begin
                $display("gmii_tx_er went high at %0d ns", $time);
                test_err[5]++;
            end
            if (rx_out.valid) begin
                rx_buf.push_back(rx_out.data);
                if (rx_out.last) begin
                    last_cnt++;
                    last_pos = rx_buf.size() - 1;
                end
            end
            if (rx_status.done) begin
                frame_done();
            end
        end
    end

    initial begin
        logic [15:0] quanta;
        seed       = 42462;
        gtx_rst    = 1'b1;
        tx_in      = '0;
        tx_valid   = 1'b0;
        gmii_rxd   = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        repeat (16) @(negedge gtx_clk);
        gtx_rst <= 1'b0;

        check_value(1, "tx_credit at reset", tx_credit, 0);
        check_value(1, "gmii_tx_en at reset", gmii_tx_en, 0);
        check_value(1, "rx_out.valid at reset", rx_out.valid, 0);
        check_value(1, "rx_status.done at reset", rx_status.done, 0);
        check_value(1, "counts at reset", counts, 0);

        @(posedge gtx_clk);
        for (int i = 0; i < NUM_LOOP; i++) begin
            random_frame(14 + ($unsigned($random(seed)) % 87));
            queue_frame(1, K_NORMAL);
        end
        wait_frames(NUM_LOOP, 1);
        report_test(1, "loopback data");

        @(posedge gtx_clk);
        random_frame(14 + ($unsigned($random(seed)) % 87));
        queue_frame(3, K_FLIP);
        random_frame(14 + ($unsigned($random(seed)) % 87));
        queue_frame(3, K_ERR);
        wait_frames(NUM_LOOP + 2, 3);
        report_test(3, "FCS and receive errors");

        @(posedge gtx_clk);
        quanta = 16'(1 + ($unsigned($random(seed)) % MAX_QUANTA));
        pause_frame(quanta);
        queue_frame(4, K_NORMAL);
        random_frame(14 + ($unsigned($random(seed)) % 87));
        queue_frame(4, K_NORMAL);
        wait_frames(NUM_FRAMES, 4);
        check_value(4, "pause holds checked", pause_checks, 1);
        report_test(4, "PAUSE");

        repeat (20) @(posedge gtx_clk); // Let credits and counters settle.
        check_value(2, "host queue left", host_q.size(), 0);
        check_value(2, "credits returned", credits_back, bytes_sent);
        check_value(2, "final credits", credits, DEPTH);
        report_test(2, "credits");

        check_value(5, "gaps checked", gap_checks, NUM_FRAMES - 1);
        report_test(5, "inter-frame gap");

        check_value(6, "tx_frames", counts.tx_frames, tally_tx);
        check_value(6, "rx_good", counts.rx_good, tally_good);
        check_value(6, "rx_bad_fcs", counts.rx_bad_fcs, tally_fcs);
        check_value(6, "rx_pause", counts.rx_pause, tally_pause);
        report_test(6, "statistics");

        total_err    = 0;
        failed_tests = 0;
        for (int i = 1; i <= 6; i++) begin
            total_err += test_err[i];
            if (test_err[i] != 0) begin
                failed_tests++;
            end
        end
        $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 failed_tests, num_checks, total_err);
        if (total_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/eth_mac_gmii.sv
// 1G Ethernet MAC, GMII
`timescale 1ns/1ps
`default_nettype none

module eth_mac_gmii (
    input  wire logic                  gtx_clk,
    input  wire logic                  gtx_rst,
    input  wire eth_mac_pkg::tx_beat_t tx_in,
    input  wire logic                  tx_valid,
    output logic                       tx_credit,
    output eth_mac_pkg::rx_beat_t      rx_out,
    output eth_mac_pkg::rx_status_t    rx_status,
    output eth_mac_pkg::mac_counts_t   counts,
    input  wire logic [7:0]            gmii_rxd,
    input  wire logic                  gmii_rx_dv,
    input  wire logic                  gmii_rx_er,
    output logic [7:0]                 gmii_txd,
    output logic                       gmii_tx_en,
    output logic                       gmii_tx_er
);

    import eth_mac_pkg::*;

    tx_beat_t   fifo_beat;
    tx_status_t tx_status;
    logic       frames_ready;
    logic       fifo_pop;

    tx_credit_fifo i_fifo (
        .gtx_clk      (gtx_clk),
        .gtx_rst      (gtx_rst),
        .tx_in        (tx_in),
        .tx_valid     (tx_valid),
        .fifo_pop     (fifo_pop),
        .fifo_beat    (fifo_beat),
        .frames_ready (frames_ready),
        .tx_credit    (tx_credit)
    );

    // Receive status doubles as the pause request.
    gmii_tx_engine i_tx (
        .gtx_clk      (gtx_clk),
        .gtx_rst      (gtx_rst),
        .fifo_beat    (fifo_beat),
        .frames_ready (frames_ready),
        .fifo_pop     (fifo_pop),
        .pause_status (rx_status),
        .gmii_txd     (gmii_txd),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_tx_er   (gmii_tx_er),
        .tx_status    (tx_status)
    );

    gmii_rx_decode i_rx (
        .gtx_clk    (gtx_clk),
        .gtx_rst    (gtx_rst),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_out     (rx_out),
        .rx_status  (rx_status)
    );

    mac_stats i_stats (
        .gtx_clk   (gtx_clk),
        .gtx_rst   (gtx_rst),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .counts    (counts)
    );

endmodule

`default_nettype wire

// File: rtl/mac_stats.sv
// MAC statistics counters
`timescale 1ns/1ps
`default_nettype none

module mac_stats (
    input  wire logic                    gtx_clk,
    input  wire logic                    gtx_rst,
    input  wire eth_mac_pkg::tx_status_t tx_status,
    input  wire eth_mac_pkg::rx_status_t rx_status,
    output eth_mac_pkg::mac_counts_t     counts
);

    logic tx_busy; // Between start and done.

    // Holds at all ones.
    function automatic logic [15:0] sat_inc(input logic [15:0] val);
        return (val == 16'hFFFF) ? val : val + 16'd1;
    endfunction

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            tx_busy <= 1'b0;
            counts  <= '0;
        end else begin
            if (tx_status.start) begin
                tx_busy <= 1'b1;
            end else if (tx_status.done) begin
                tx_busy <= 1'b0;
            end
            if (tx_status.done && tx_busy) begin
                counts.tx_frames <= sat_inc(counts.tx_frames);
            end

            if (rx_status.done) begin
                if (rx_status.good) begin
                    counts.rx_good <= sat_inc(counts.rx_good);
                end
                if (rx_status.bad_fcs) begin
                    counts.rx_bad_fcs <= sat_inc(counts.rx_bad_fcs);
                end
                if (rx_status.pause_valid) begin
                    counts.rx_pause <= sat_inc(counts.rx_pause);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/gmii_rx_decode.sv
// GMII receive decoder
`timescale 1ns/1ps
`default_nettype none
`include "eth_mac_consts.svh"

module gmii_rx_decode (
    input  wire logic               gtx_clk,
    input  wire logic               gtx_rst,
    input  wire logic [7:0]         gmii_rxd,
    input  wire logic               gmii_rx_dv,
    input  wire logic               gmii_rx_er,
    output eth_mac_pkg::rx_beat_t   rx_out,
    output eth_mac_pkg::rx_status_t rx_status
);

    localparam logic [47:0] PAUSE_DST = `ETH_PAUSE_DST;
    localparam logic [15:0] CTRL_TYPE = `ETH_CTRL_TYPE;
    localparam logic [15:0] PAUSE_OP  = `ETH_PAUSE_OPCODE;

    logic [7:0]      rxd_q;
    logic            dv_q;
    logic            er_q;
    logic            in_frame; // Past the SFD.
    logic [15:0]     byte_cnt;
    logic [31:0]     crc;
    logic [31:0]     crc_next;
    logic [3:0][7:0] dly;      // Holds back the FCS.
    logic            err;
    logic            is_pause;
    logic [15:0]     quanta;
    logic            crc_ok;
    logic            len_ok;
    logic            err_any;

    always_ff @(posedge gtx_clk) begin
        rxd_q <= gmii_rxd;
        er_q  <= gmii_rx_er;
        if (gtx_rst) begin
            dv_q <= 1'b0;
        end else begin
            dv_q <= gmii_rx_dv;
        end
    end

    eth_crc32 i_crc (
        .crc_in  (crc),
        .data    (rxd_q),
        .crc_out (crc_next)
    );

    // Checks for the final byte, FCS included.
    assign crc_ok  = (crc_next == `ETH_CRC_RESIDUE);
    assign len_ok  = (byte_cnt + 1 >= `ETH_MIN_FRAME_LEN);
    assign err_any = err || er_q;

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            in_frame     <= 1'b0;
            byte_cnt     <= '0;
            rx_out.valid <= 1'b0;
            rx_status    <= '0;
        end else begin
            rx_out.valid   <= 1'b0;
            rx_status.done <= 1'b0;
            if (!in_frame) begin
                if (dv_q && rxd_q == 8'hD5) begin
                    in_frame <= 1'b1;
                    byte_cnt <= '0;
                    crc      <= '1;
                    err      <= 1'b0;
                    is_pause <= 1'b1;
                end
            end else if (!dv_q) begin
                in_frame <= 1'b0; // Nothing after the SFD.
            end else begin
                dly          <= {dly[2:0], rxd_q};
                crc          <= crc_next;
                byte_cnt     <= byte_cnt + 1'b1;
                err          <= err_any;
                rx_out.data  <= dly[3];
                rx_out.last  <= !gmii_rx_dv; // Next input byte is gone.
                rx_out.valid <= (byte_cnt >= 16'd4);

                // Header match while bytes pass by.
                if (byte_cnt < 16'd6) begin
                    if (rxd_q != PAUSE_DST[8*(5 - byte_cnt[2:0]) +: 8]) begin
                        is_pause <= 1'b0;
                    end
                end else begin
                    case (byte_cnt)
                        16'd12: is_pause <= is_pause && (rxd_q == CTRL_TYPE[15:8]);
                        16'd13: is_pause <= is_pause && (rxd_q == CTRL_TYPE[7:0]);
                        16'd14: is_pause <= is_pause && (rxd_q == PAUSE_OP[15:8]);
                        16'd15: is_pause <= is_pause && (rxd_q == PAUSE_OP[7:0]);
                        16'd16: quanta[15:8] <= rxd_q;
                        16'd17: quanta[7:0]  <= rxd_q;
                        default: ;
                    endcase
                end

                if (!gmii_rx_dv) begin
                    in_frame               <= 1'b0;
                    rx_status.done         <= 1'b1;
                    rx_status.good         <= crc_ok && !err_any && len_ok;
                    rx_status.bad_fcs      <= !crc_ok;
                    rx_status.bad_frame    <= err_any || !len_ok;
                    rx_status.pause_valid  <= crc_ok && !err_any && len_ok && is_pause;
                    rx_status.pause_quanta <= quanta;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/gmii_tx_engine.sv
// GMII transmit engine
`timescale 1ns/1ps
`default_nettype none
`include "eth_mac_consts.svh"

module gmii_tx_engine (
    input  wire logic                    gtx_clk,
    input  wire logic                    gtx_rst,
    input  wire eth_mac_pkg::tx_beat_t   fifo_beat,
    input  wire logic                    frames_ready,
    output logic                         fifo_pop,
    input  wire eth_mac_pkg::rx_status_t pause_status,
    output logic [7:0]                   gmii_txd,
    output logic                         gmii_tx_en,
    output logic                         gmii_tx_er,
    output eth_mac_pkg::tx_status_t      tx_status
);

    localparam int         PAD_LEN  = `ETH_MIN_FRAME_LEN - 4; // Data bytes before FCS.
    localparam int         PAUSE_W  = 16 + $clog2(`ETH_PAUSE_QUANTUM_CYCLES);
    localparam logic [7:0] GAP_LAST = 8'(`ETH_IFG_BYTES - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PREAMBLE,
        S_DATA,
        S_PAD,
        S_FCS,
        S_GAP
    } state_t;

    state_t             state;
    logic [7:0]         cnt;   // Preamble, FCS or gap position.
    logic [7:0]         len;   // Bytes after the SFD.
    logic [31:0]        crc;
    logic [31:0]        crc_next;
    logic [7:0]         crc_byte;
    logic [PAUSE_W-1:0] pause_cnt;
    logic               pause_load;
    logic               start_ok;

    assign crc_byte = (state == S_DATA) ? fifo_beat.data : 8'h00;

    eth_crc32 i_crc (
        .crc_in  (crc),
        .data    (crc_byte),
        .crc_out (crc_next)
    );

    assign fifo_pop   = (state == S_DATA);
    assign gmii_tx_er = 1'b0;
    assign pause_load = pause_status.done && pause_status.pause_valid;
    assign start_ok   = frames_ready && (pause_cnt == '0) && !pause_load;

    // Pause countdown, a new PAUSE reloads it.
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            pause_cnt <= '0;
        end else if (pause_load) begin
            pause_cnt <= PAUSE_W'(pause_status.pause_quanta) *
                         PAUSE_W'(`ETH_PAUSE_QUANTUM_CYCLES);
        end else if (pause_cnt != '0) begin
            pause_cnt <= pause_cnt - 1'b1;
        end
    end

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state      <= S_IDLE;
            cnt        <= '0;
            len        <= '0;
            gmii_tx_en <= 1'b0;
            tx_status  <= '0;
        end else begin
            tx_status <= '0;
            case (state)
                S_IDLE: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= 8'h00;
                    if (start_ok) begin
                        gmii_tx_en      <= 1'b1;
                        gmii_txd        <= 8'h55; // First preamble byte.
                        tx_status.start <= 1'b1;
                        cnt             <= 8'd1;
                        state           <= S_PREAMBLE;
                    end
                end
                S_PREAMBLE: begin
                    crc <= '1;
                    len <= '0;
                    cnt <= cnt + 1'b1;
                    if (cnt == 8'd7) begin
                        gmii_txd <= 8'hD5; // SFD.
                        state    <= S_DATA;
                    end else begin
                        gmii_txd <= 8'h55;
                    end
                end
                S_DATA: begin
                    gmii_txd <= fifo_beat.data;
                    crc      <= crc_next;
                    len      <= len + 1'b1;
                    if (fifo_beat.last) begin
                        cnt   <= '0;
                        state <= (len + 1 < PAD_LEN) ? S_PAD : S_FCS;
                    end
                end
                S_PAD: begin
                    gmii_txd <= 8'h00;
                    crc      <= crc_next;
                    len      <= len + 1'b1;
                    if (len + 1 == PAD_LEN) begin
                        state <= S_FCS;
                    end
                end
                S_FCS: begin
                    gmii_txd <= ~crc[8*cnt[1:0] +: 8]; // Low byte first.
                    cnt      <= cnt + 1'b1;
                    if (cnt == 8'd3) begin
                        tx_status.done <= 1'b1;
                        cnt            <= '0;
                        state          <= S_GAP;
                    end
                end
                S_GAP: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= 8'h00;
                    cnt        <= cnt + 1'b1;
                    if (cnt == GAP_LAST) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tx_credit_fifo.sv
// Transmit credit FIFO
`timescale 1ns/1ps
`default_nettype none
`include "eth_mac_consts.svh"

module tx_credit_fifo (
    input  wire logic                  gtx_clk,
    input  wire logic                  gtx_rst,
    input  wire eth_mac_pkg::tx_beat_t tx_in,
    input  wire logic                  tx_valid,
    input  wire logic                  fifo_pop,
    output eth_mac_pkg::tx_beat_t      fifo_beat,
    output logic                       frames_ready,
    output logic                       tx_credit
);

    import eth_mac_pkg::*;

    localparam int DEPTH  = `ETH_TX_FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    tx_beat_t          mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   frame_cnt; // Whole frames held.
    logic              frame_in;
    logic              frame_out;

    assign frame_in  = tx_valid && tx_in.last;
    assign frame_out = fifo_pop && fifo_beat.last;

    always_ff @(posedge gtx_clk) begin
        if (tx_valid) begin
            mem[wr_ptr] <= tx_in;
        end
    end

    // Head of queue is always on the output.
    assign fifo_beat = mem[rd_ptr];

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
            tx_credit <= 1'b0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // Credits keep this from overrunning.
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (frame_in && !frame_out) begin
                frame_cnt <= frame_cnt + 1'b1;
            end else if (frame_out && !frame_in) begin
                frame_cnt <= frame_cnt - 1'b1;
            end
            tx_credit <= fifo_pop; // One credit per byte drained.
        end
    end

    assign frames_ready = (frame_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/eth_crc32.sv
// Ethernet CRC-32 byte step
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
    input  wire logic [31:0] crc_in,
    input  wire logic [7:0]  data,
    output logic [31:0]      crc_out
);

    localparam logic [31:0] POLY = 32'hEDB8_8320; // Reflected form of 04C11DB7.

    logic [31:0] crc;

    // Bit 0 of the byte goes in first.
    always_comb begin
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

// File: rtl/eth_mac_pkg.sv
// MAC shared types
`default_nettype none

package eth_mac_pkg;

    // Host transmit beat.
    typedef struct packed {
        logic [7:0] data;
        logic       last; // Final byte of the frame.
    } tx_beat_t;

    // Receive beat to the host.
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last; // Byte before the FCS.
    } rx_beat_t;

    // Receive result, fields valid with done.
    typedef struct packed {
        logic        done;
        logic        good;
        logic        bad_fcs;
        logic        bad_frame;
        logic        pause_valid;
        logic [15:0] pause_quanta;
    } rx_status_t;

    typedef struct packed {
        logic start; // First preamble byte.
        logic done;  // Last FCS byte.
    } tx_status_t;

    // Statistics counters.
    typedef struct packed {
        logic [15:0] tx_frames;
        logic [15:0] rx_good;
        logic [15:0] rx_bad_fcs;
        logic [15:0] rx_pause;
    } mac_counts_t;

endpackage

`default_nettype wire

// File: rtl/eth_mac_consts.svh
// Ethernet MAC constants
`ifndef ETH_MAC_CONSTS_SVH
`define ETH_MAC_CONSTS_SVH

// Transmit FIFO size in bytes, also the host's starting credit.
`define ETH_TX_FIFO_DEPTH 128

// Shortest legal frame, FCS included.
`define ETH_MIN_FRAME_LEN 64

// Idle byte times between frames.
`define ETH_IFG_BYTES 12

// Clock cycles per pause quantum.
`define ETH_PAUSE_QUANTUM_CYCLES 64

// PAUSE frame fields.
`define ETH_PAUSE_DST 48'h01_80_C2_00_00_01
`define ETH_CTRL_TYPE 16'h8808
`define ETH_PAUSE_OPCODE 16'h0001

// CRC register after a good frame and its FCS.
`define ETH_CRC_RESIDUE 32'hDEBB_20E3

`endif
